// ==== src/btb_pkg.sv ====
`default_nettype none

package btb_pkg;

    // byte address of one instruction
    typedef logic [31:0] addr_t;

    localparam addr_t RESET_PC = 32'h0000_1000; // first fetch after reset

    // where the next fetch pc comes from
    typedef enum logic [1:0] {
        PC_SEL_HOLD     = 2'd0, // fetch stalled
        PC_SEL_SEQ      = 2'd1, // fall through
        PC_SEL_PRED     = 2'd2, // taken, target from the btb
        PC_SEL_REDIRECT = 2'd3  // execute says we went wrong
    } pc_sel_e;

endpackage

`default_nettype wire

// ==== src/plru_tree.sv ====
`timescale 1ns/1ns
`default_nettype none

// tree pseudo-lru for one set
// node n has children 2n+1 (left) and 2n+2 (right), root is node 0
module plru_tree #(
    parameter int WAYS = 4
) (
    input  logic [WAYS-2:0]         plru_old,
    input  logic [$clog2(WAYS)-1:0] access_line,
    output logic [WAYS-2:0]         plru_new,
    output logic [$clog2(WAYS)-1:0] victim_line
);

    localparam int LEVELS = $clog2(WAYS);

    // follow the bits down, 0 goes left
    always_comb begin
        int node;
        node = 0;
        victim_line = '0;
        for (int lvl = 0; lvl < LEVELS; lvl++) begin
            victim_line[LEVELS-1-lvl] = plru_old[node];
            node = 2 * node + 1 + int'(plru_old[node]);
        end
    end

    // every node on the accessed path is turned to point the other way
    always_comb begin
        int node;
        logic dir;
        node = 0;
        plru_new = plru_old;
        for (int lvl = 0; lvl < LEVELS; lvl++) begin
            dir = access_line[LEVELS-1-lvl]; // msb picks the root side
            plru_new[node] = ~dir;
            node = 2 * node + 1 + int'(dir);
        end
    end

endmodule

`default_nettype wire

// ==== src/lutram_dual_port.sv ====
`timescale 1ns/1ns
`default_nettype none

// distributed ram, one write port plus two async read ports
module lutram_dual_port #(
    parameter int ADDR_WIDTH = 3,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [ADDR_WIDTH-1:0] raddr_2,
    output logic [DATA_WIDTH-1:0] rdata_1,
    output logic [DATA_WIDTH-1:0] rdata_2
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // port 1 reads where it writes, so the old row is visible before the edge
    assign rdata_1 = mem[waddr];
    assign rdata_2 = mem[raddr_2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== src/btb.sv ====
`timescale 1ns/1ns
`default_nettype none

// set associative branch target buffer
// port 2 of each ram serves the lookup, port 1 the update
module btb import btb_pkg::*; #(
    parameter int WAYS = 4,
    parameter int SETS = 8
) (
    input  logic  clk,
    input  logic  reset,
    input  addr_t lookup_pc,
    input  logic  lookup_en,
    input  logic  update_valid,
    input  addr_t update_pc,
    input  addr_t update_target,
    input  logic  update_is_jump,
    output logic  hit,
    output addr_t target,
    output logic  is_jump
);

    localparam int INDEX_BITS = $clog2(SETS);
    localparam int WAY_BITS   = $clog2(WAYS);
    localparam int TAG_BITS   = 30 - INDEX_BITS;
    localparam int META_BITS  = TAG_BITS + 1; // jump flag above the tag

    logic [INDEX_BITS-1:0] lookup_idx;
    logic [INDEX_BITS-1:0] update_idx;
    logic [TAG_BITS-1:0]   lookup_tag;
    logic [TAG_BITS-1:0]   update_tag;

    logic [WAYS-1:0][META_BITS-1:0] meta_lookup;
    logic [WAYS-1:0][META_BITS-1:0] meta_update; // old row of the update set
    logic [WAYS-1:0][META_BITS-1:0] meta_wdata;

    logic [SETS-1:0][WAYS-1:0] valid_q;
    logic [SETS-1:0][WAYS-2:0] plru_q;

    logic [WAY_BITS-1:0] hit_way;
    logic [WAY_BITS-1:0] match_way;
    logic [WAY_BITS-1:0] victim_way;
    logic [WAY_BITS-1:0] write_way;
    logic                update_match;
    logic                lookup_touch;

    logic [WAYS-2:0] lookup_plru_new;
    logic [WAYS-2:0] update_plru_old;
    logic [WAYS-2:0] update_plru_new;
    addr_t           target_rd;

    assign lookup_idx = lookup_pc[INDEX_BITS+1:2];
    assign lookup_tag = lookup_pc[31:INDEX_BITS+2];
    assign update_idx = update_pc[INDEX_BITS+1:2];
    assign update_tag = update_pc[31:INDEX_BITS+2];

    // lookup, lowest matching way wins
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (valid_q[lookup_idx][i] && meta_lookup[i][TAG_BITS-1:0] == lookup_tag) begin
                hit = 1'b1;
                hit_way = WAY_BITS'(i);
            end
        end
    end

    assign is_jump = hit & meta_lookup[hit_way][TAG_BITS];
    assign target  = hit ? target_rd : '0;

    // is the update pc already in its set
    always_comb begin
        update_match = 1'b0;
        match_way = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (valid_q[update_idx][i] && meta_update[i][TAG_BITS-1:0] == update_tag) begin
                update_match = 1'b1;
                match_way = WAY_BITS'(i);
            end
        end
    end

    assign write_way = update_match ? match_way : victim_way;

    always_comb begin
        meta_wdata = meta_update;
        meta_wdata[write_way] = {update_is_jump, update_tag};
    end

    assign lookup_touch = lookup_en & hit;

    // same set touched by both ports: update goes on top of the hit
    assign update_plru_old = (lookup_touch && lookup_idx == update_idx) ?
                             lookup_plru_new : plru_q[update_idx];

    plru_tree #(
        .WAYS(WAYS)
    ) lookup_plru (
        .plru_old    (plru_q[lookup_idx]),
        .access_line (hit_way),
        .plru_new    (lookup_plru_new),
        .victim_line ()                  // lookups never allocate
    );

    plru_tree #(
        .WAYS(WAYS)
    ) update_plru (
        .plru_old    (update_plru_old),
        .access_line (write_way),
        .plru_new    (update_plru_new),
        .victim_line (victim_way)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            plru_q  <= '0;
        end else begin
            if (lookup_touch) begin
                plru_q[lookup_idx] <= lookup_plru_new;
            end
            if (update_valid) begin
                valid_q[update_idx][write_way] <= 1'b1;
                plru_q[update_idx] <= update_plru_new; // later write wins
            end
        end
    end

    // one row per set, tag and jump flag of every way
    lutram_dual_port #(
        .ADDR_WIDTH (INDEX_BITS),
        .DATA_WIDTH (WAYS * META_BITS)
    ) meta_ram (
        .clk     (clk),
        .we      (update_valid),
        .waddr   (update_idx),
        .wdata   (meta_wdata),
        .raddr_2 (lookup_idx),
        .rdata_1 (meta_update),
        .rdata_2 (meta_lookup)
    );

    // one target per set and way
    lutram_dual_port #(
        .ADDR_WIDTH (INDEX_BITS + WAY_BITS),
        .DATA_WIDTH ($bits(addr_t))
    ) target_ram (
        .clk     (clk),
        .we      (update_valid),
        .waddr   ({update_idx, write_way}),
        .wdata   (update_target),
        .raddr_2 ({lookup_idx, hit_way}),
        .rdata_1 (),
        .rdata_2 (target_rd)
    );

endmodule

`default_nettype wire

// ==== src/fetch_pc_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

// f1 pc register, next pc mux and the f2 stage
module fetch_pc_gen import btb_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  fetch_en,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    input  logic  pred_hit,
    input  addr_t pred_target,
    input  logic  pred_is_jump,
    output addr_t lookup_pc,
    output logic  lookup_en,
    output logic  f2_valid,
    output addr_t f2_pc,
    output logic  f2_pred_hit,
    output addr_t f2_pred_target,
    output logic  f2_pred_is_jump
);

    addr_t   pc_q;
    addr_t   pc_next;
    pc_sel_e pc_sel;

    assign lookup_pc = pc_q;
    assign lookup_en = fetch_en & ~redirect_valid; // f1 pc accepted this cycle

    // redirect beats stall beats prediction
    always_comb begin
        if (redirect_valid) begin
            pc_sel = PC_SEL_REDIRECT;
        end else if (!fetch_en) begin
            pc_sel = PC_SEL_HOLD;
        end else if (pred_hit) begin
            pc_sel = PC_SEL_PRED;
        end else begin
            pc_sel = PC_SEL_SEQ;
        end
    end

    always_comb begin
        case (pc_sel)
            PC_SEL_HOLD:     pc_next = pc_q;
            PC_SEL_SEQ:      pc_next = pc_q + 32'd4;
            PC_SEL_PRED:     pc_next = pred_target;
            PC_SEL_REDIRECT: pc_next = redirect_pc;
            default:         pc_next = pc_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q        <= RESET_PC;
            f2_valid    <= 1'b0;
            f2_pred_hit <= 1'b0;
        end else begin
            pc_q     <= pc_next;
            f2_valid <= lookup_en; // redirect squashes the f1 pc
            if (lookup_en) begin
                f2_pred_hit <= pred_hit;
            end
        end
    end

    // f2 payload, only moves with an accepted fetch
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            f2_pc           <= pc_q;
            f2_pred_target  <= pred_target;
            f2_pred_is_jump <= pred_is_jump;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_predict_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// fetch side prediction, pc stage plus target buffer
module fetch_predict_top import btb_pkg::*; #(
    parameter int WAYS = 4,
    parameter int SETS = 8
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  fetch_en,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    input  logic  update_valid,
    input  addr_t update_pc,
    input  addr_t update_target,
    input  logic  update_is_jump,
    output logic  f2_valid,
    output addr_t f2_pc,
    output logic  f2_pred_hit,
    output addr_t f2_pred_target,
    output logic  f2_pred_is_jump
);

    addr_t lookup_pc;
    logic  lookup_en;
    logic  pred_hit;
    addr_t pred_target;
    logic  pred_is_jump;

    fetch_pc_gen pc_gen (
        .clk             (clk),
        .reset           (reset),
        .fetch_en        (fetch_en),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .pred_hit        (pred_hit),
        .pred_target     (pred_target),
        .pred_is_jump    (pred_is_jump),
        .lookup_pc       (lookup_pc),
        .lookup_en       (lookup_en),
        .f2_valid        (f2_valid),
        .f2_pc           (f2_pc),
        .f2_pred_hit     (f2_pred_hit),
        .f2_pred_target  (f2_pred_target),
        .f2_pred_is_jump (f2_pred_is_jump)
    );

    // update port comes straight from execute
    btb #(
        .WAYS (WAYS),
        .SETS (SETS)
    ) target_buffer (
        .clk            (clk),
        .reset          (reset),
        .lookup_pc      (lookup_pc),
        .lookup_en      (lookup_en),
        .update_valid   (update_valid),
        .update_pc      (update_pc),
        .update_target  (update_target),
        .update_is_jump (update_is_jump),
        .hit            (pred_hit),
        .target         (pred_target),
        .is_jump        (pred_is_jump)
    );

endmodule

`default_nettype wire

// ==== verification/fetch_predict_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

// reference model of the fetch pipe and the target buffer
// steps on the rising edge and compares on the falling edge
module fetch_predict_checker import btb_pkg::*; #(
    parameter int WAYS = 4,
    parameter int SETS = 8
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  fetch_en,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    input  logic  update_valid,
    input  addr_t update_pc,
    input  addr_t update_target,
    input  logic  update_is_jump,
    input  logic  f2_valid,
    input  addr_t f2_pc,
    input  logic  f2_pred_hit,
    input  addr_t f2_pred_target,
    input  logic  f2_pred_is_jump,
    output int    error_count,
    output int    hit_count
);

    localparam int IDX_BITS = $clog2(SETS);

    addr_t           m_pc;
    logic            m_f2_valid;
    addr_t           m_f2_pc;
    logic            m_f2_hit;
    addr_t           m_f2_target;
    logic            m_f2_jump;
    addr_t           m_tag [SETS][WAYS];
    addr_t           m_tgt [SETS][WAYS];
    logic            m_jmp [SETS][WAYS];
    logic            m_vld [SETS][WAYS];
    logic [WAYS-2:0] m_plru [SETS];
    logic            live = 1'b0; // set by the first reset edge
    int              errors = 0;
    int              hits = 0;

    assign error_count = errors;
    assign hit_count   = hits;

    function automatic int set_of(addr_t pc);
        return int'((pc >> 2) % SETS);
    endfunction

    function automatic addr_t tag_of(addr_t pc);
        return pc >> (IDX_BITS + 2);
    endfunction

    // a set bit picks the right half of the way range
    function automatic int plru_victim(logic [WAYS-2:0] bits);
        int node;
        int lo;
        int span;
        node = 0;
        lo = 0;
        span = WAYS;
        while (span > 1) begin
            span = span / 2;
            if (bits[node]) begin
                lo = lo + span;
                node = 2 * node + 2;
            end else begin
                node = 2 * node + 1;
            end
        end
        return lo;
    endfunction

    function automatic logic [WAYS-2:0] plru_touch(logic [WAYS-2:0] bits, int way);
        logic [WAYS-2:0] result;
        int node;
        int lo;
        int span;
        result = bits;
        node = 0;
        lo = 0;
        span = WAYS;
        while (span > 1) begin
            span = span / 2;
            if (way >= lo + span) begin
                result[node] = 1'b0; // way sits right so point left
                lo = lo + span;
                node = 2 * node + 2;
            end else begin
                result[node] = 1'b1;
                node = 2 * node + 1;
            end
        end
        return result;
    endfunction

    always @(posedge clk) begin
        int    l_set;
        int    l_way;
        int    u_set;
        int    u_way;
        logic  l_hit;
        logic  l_jump;
        logic  u_found;
        logic  accept;
        addr_t l_target;
        if (reset) begin
            live = 1'b1;
            m_pc = RESET_PC;
            m_f2_valid = 1'b0;
            m_f2_hit = 1'b0;
            for (int s = 0; s < SETS; s++) begin
                m_plru[s] = '0;
                for (int w = 0; w < WAYS; w++) begin
                    m_vld[s][w] = 1'b0;
                end
            end
        end else if (live) begin
            accept = fetch_en && !redirect_valid;
            l_set = set_of(m_pc);
            l_hit = 1'b0;
            l_way = 0;
            for (int w = 0; w < WAYS; w++) begin
                if (!l_hit && m_vld[l_set][w] && m_tag[l_set][w] == tag_of(m_pc)) begin
                    l_hit = 1'b1;
                    l_way = w;
                end
            end
            l_target = m_tgt[l_set][l_way]; // old contents
            l_jump = m_jmp[l_set][l_way];
            if (accept && l_hit) begin
                m_plru[l_set] = plru_touch(m_plru[l_set], l_way);
            end
            if (update_valid) begin
                u_set = set_of(update_pc);
                u_found = 1'b0;
                u_way = 0;
                for (int w = 0; w < WAYS; w++) begin
                    if (!u_found && m_vld[u_set][w] && m_tag[u_set][w] == tag_of(update_pc)) begin
                        u_found = 1'b1;
                        u_way = w;
                    end
                end
                if (!u_found) begin
                    u_way = plru_victim(m_plru[u_set]);
                end
                m_tag[u_set][u_way] = tag_of(update_pc);
                m_tgt[u_set][u_way] = update_target;
                m_jmp[u_set][u_way] = update_is_jump;
                m_vld[u_set][u_way] = 1'b1;
                m_plru[u_set] = plru_touch(m_plru[u_set], u_way);
            end
            m_f2_valid = accept;
            if (accept) begin
                m_f2_pc = m_pc;
                m_f2_hit = l_hit;
                m_f2_target = l_target;
                m_f2_jump = l_jump;
                if (l_hit) begin
                    hits++;
                end
            end
            if (redirect_valid) begin
                m_pc = redirect_pc;
            end else if (fetch_en) begin
                m_pc = l_hit ? l_target : m_pc + 32'd4;
            end
        end
    end

    task automatic check_flag(input string name, input logic dut, input logic model);
        if (dut !== model) begin
            errors++;
            $display("error %s: dut 0x%01h model 0x%01h at %0t", name, dut, model, $time);
        end
    endtask

    task automatic check_word(input string name, input addr_t dut, input addr_t model);
        if (dut !== model) begin
            errors++;
            $display("error %s: dut 0x%08h model 0x%08h at %0t", name, dut, model, $time);
        end
    endtask

    always @(negedge clk) begin
        if (live) begin
            check_flag("f2_valid", f2_valid, m_f2_valid);
            if (m_f2_valid) begin // payload only means something with valid
                check_word("f2_pc", f2_pc, m_f2_pc);
                check_flag("f2_pred_hit", f2_pred_hit, m_f2_hit);
                if (m_f2_hit) begin // target and jump flag only come with a hit
                    check_word("f2_pred_target", f2_pred_target, m_f2_target);
                    check_flag("f2_pred_is_jump", f2_pred_is_jump, m_f2_jump);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/fetch_predict_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_predict_tb import btb_pkg::*; ();

    localparam int WAYS       = 4;
    localparam int SETS       = 8;
    localparam int POOL_TAGS  = 6; // more tags than ways per set
    localparam int RUN_CYCLES = 3000;
    localparam int WAIT_LIMIT = 50;

    logic  clk = 1'b0;
    logic  reset;
    logic  fetch_en;
    logic  redirect_valid;
    addr_t redirect_pc;
    logic  update_valid;
    addr_t update_pc;
    addr_t update_target;
    logic  update_is_jump;
    logic  f2_valid;
    addr_t f2_pc;
    logic  f2_pred_hit;
    addr_t f2_pred_target;
    logic  f2_pred_is_jump;
    int    check_errors;
    int    hit_total;
    int    run_errors = 0;

    always #20 clk = ~clk;

    fetch_predict_top #(
        .WAYS (WAYS),
        .SETS (SETS)
    ) fetch_predict_top_inst (
        .clk             (clk),
        .reset           (reset),
        .fetch_en        (fetch_en),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .update_valid    (update_valid),
        .update_pc       (update_pc),
        .update_target   (update_target),
        .update_is_jump  (update_is_jump),
        .f2_valid        (f2_valid),
        .f2_pc           (f2_pc),
        .f2_pred_hit     (f2_pred_hit),
        .f2_pred_target  (f2_pred_target),
        .f2_pred_is_jump (f2_pred_is_jump)
    );

    fetch_predict_checker #(
        .WAYS (WAYS),
        .SETS (SETS)
    ) checker_inst (
        .clk             (clk),
        .reset           (reset),
        .fetch_en        (fetch_en),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .update_valid    (update_valid),
        .update_pc       (update_pc),
        .update_target   (update_target),
        .update_is_jump  (update_is_jump),
        .f2_valid        (f2_valid),
        .f2_pc           (f2_pc),
        .f2_pred_hit     (f2_pred_hit),
        .f2_pred_target  (f2_pred_target),
        .f2_pred_is_jump (f2_pred_is_jump),
        .error_count     (check_errors),
        .hit_count       (hit_total)
    );

    // word address near the reset pc, any set, one of a few tags
    function automatic addr_t pool_pc();
        addr_t tag_part;
        addr_t set_part;
        tag_part = addr_t'($urandom_range(POOL_TAGS - 1, 0)) << (2 + $clog2(SETS));
        set_part = addr_t'($urandom_range(SETS - 1, 0)) << 2;
        return RESET_PC + tag_part + set_part;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        fetch_en = 1'b0;
        redirect_valid = 1'b0;
        update_valid = 1'b0;
        repeat (2) next_cycle();
        reset = 1'b0;
    endtask

    task automatic wait_first_fetch();
        int cycles;
        cycles = 0;
        fetch_en = 1'b1;
        while (!f2_valid && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (!f2_valid) begin
            $display("timeout: no fetch reached f2 after reset");
            run_errors++;
        end
    endtask

    // straight line fetch, no updates, so every lookup misses
    task automatic quiet_fetch(input int n);
        fetch_en = 1'b1;
        redirect_valid = 1'b0;
        update_valid = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic random_inputs();
        fetch_en = ($urandom_range(99, 0) < 85);
        redirect_valid = ($urandom_range(19, 0) == 0);
        redirect_pc = pool_pc();
        update_valid = ($urandom_range(3, 0) == 0);
        update_pc = pool_pc();
        update_target = pool_pc(); // keeps predicted paths inside the pool
        update_is_jump = ($urandom_range(1, 0) == 1);
    endtask

    initial begin
        void'($urandom(32'h7a761476));
        reset = 1'b1;
        fetch_en = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        update_valid = 1'b0;
        update_pc = '0;
        update_target = '0;
        update_is_jump = 1'b0;
        apply_reset();
        wait_first_fetch();
        quiet_fetch(16);
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            if (cyc == RUN_CYCLES / 2) begin // reset with a full buffer
                apply_reset();
                wait_first_fetch();
                quiet_fetch(16);
            end
            random_inputs();
            next_cycle();
        end
        quiet_fetch(2);
        if (hit_total == 0) begin
            $display("no prediction hit was seen during the run");
            run_errors++;
        end
        $display("errors: compare %0d, run %0d", check_errors, run_errors);
        if (check_errors == 0 && run_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_predict_top.f ====
src/btb_pkg.sv
src/plru_tree.sv
src/lutram_dual_port.sv
src/btb.sv
src/fetch_pc_gen.sv
src/fetch_predict_top.sv
verification/fetch_predict_checker.sv
verification/fetch_predict_tb.sv

// ==== Makefile ====
TOP = fetch_predict_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f fetch_predict_top.f -o sim_$(TOP)

run: compile
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
